// ==== rtl/cps_mem_pkg.sv ====
`default_nettype none

package cps_mem_pkg;

    // SDRAM geometry as seen by the slots
    localparam int SDRAM_AW = 22;
    localparam int SLOT_DW  = 32;

    // Word bases inside each bank
    localparam logic [21:0] SOUND_OFFSET = 22'h00_0000;
    localparam logic [21:0] RAM_OFFSET   = 22'h20_0000;
    localparam logic [21:0] VRAM_OFFSET  = 22'h30_0000;
    localparam logic [21:0] GFX_OFFSET   = 22'h00_0000;

    // Byte addresses in the download stream
    localparam logic [24:0] SND_START = 25'h20_0000;
    localparam logic [24:0] GFX_START = 25'h24_0000;

    typedef enum logic [1:0] {
        BANK_SOUND = 2'd0,
        BANK_CPU   = 2'd1,
        BANK_GFX   = 2'd2
    } sdram_bank_e;

    // Listed from highest to lowest priority
    typedef enum logic [1:0] {
        SLOT_MAIN_ROM,
        SLOT_MAIN_RAM,
        SLOT_GFX,
        SLOT_SOUND
    } slot_id_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

endpackage

`default_nettype wire

// ==== rtl/sdram_slot_if.sv ====
`default_nettype none

interface sdram_slot_if;
    import cps_mem_pkg::*;

    // Request side, held stable until done
    logic                req;
    logic [SDRAM_AW-1:0] addr;
    logic                wr;
    logic [15:0]         din;
    logic [1:0]          wrmask;

    // One-cycle completion with read data
    logic                done;
    logic [SLOT_DW-1:0]  dout;

    modport client  (output req, addr, wr, din, wrmask, input done, dout);
    modport arbiter (input req, addr, wr, din, wrmask, output done, dout);

endinterface

`default_nettype wire

// ==== rtl/rom_loader.sv ====
`default_nettype none

module rom_loader (
    input  logic                                  VB,
    input  logic                                  reset,
    input  logic                                  downloading,
    input  logic [24:0]                           ioctl_addr,
    input  logic [7:0]                            ioctl_data,
    input  logic                                  ioctl_wr,
    input  logic                                  sdram_ack,
    output logic [cps_mem_pkg::SDRAM_AW-1:0]      prog_addr,
    output logic [7:0]                            prog_data,
    output logic [1:0]                            prog_mask,
    output cps_mem_pkg::sdram_bank_e              prog_bank,
    output logic                                  prog_we
);
    import cps_mem_pkg::*;

    logic [24:0]         rel_addr;
    logic [SDRAM_AW-1:0] word_addr;
    sdram_bank_e         bank;

    // Region decode, graphics sits above sound
    always_comb begin
        if (ioctl_addr >= GFX_START) begin
            bank      = BANK_GFX;
            rel_addr  = ioctl_addr - GFX_START;
            word_addr = GFX_OFFSET + rel_addr[22:1];
        end else if (ioctl_addr >= SND_START) begin
            bank      = BANK_SOUND;
            rel_addr  = ioctl_addr - SND_START;
            word_addr = SOUND_OFFSET + rel_addr[22:1];
        end else begin
            bank      = BANK_CPU;
            rel_addr  = ioctl_addr;
            word_addr = rel_addr[22:1];
        end
    end

    always_ff @(posedge VB) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (prog_we && sdram_ack) begin
            prog_we <= 1'b0;
        end else if (downloading && ioctl_wr) begin
            prog_we <= 1'b1;
        end
    end

    // Write fields, a set mask bit keeps that lane
    always_ff @(posedge VB) begin
        if (downloading && ioctl_wr) begin
            prog_addr <= word_addr;
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog_bank <= bank;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rom_slot_cache.sv ====
`default_nettype none

module rom_slot_cache #(
    parameter int DW = 16
) (
    input  logic                             VB,
    input  logic                             reset,
    input  logic                             cs,
    input  logic [cps_mem_pkg::SDRAM_AW-1:0] addr,
    output logic [DW-1:0]                    data,
    output logic                             ok,
    sdram_slot_if.client                     slot
);

    logic                             valid;
    logic [cps_mem_pkg::SDRAM_AW-1:0] tag;
    logic [DW-1:0]                    cache_data;
    logic                             hit;

    assign hit  = valid && (tag == addr);
    assign ok   = cs && hit;
    assign data = cache_data;

    // Read-only client
    assign slot.addr   = addr;
    assign slot.wr     = 1'b0;
    assign slot.din    = 16'd0;
    assign slot.wrmask = 2'b11;

    always_ff @(posedge VB) begin
        if (reset) begin
            slot.req <= 1'b0;
            valid    <= 1'b0;
        end else if (slot.done) begin
            slot.req <= 1'b0;
            valid    <= 1'b1;
        end else if (cs && !hit) begin
            slot.req <= 1'b1;
        end
    end

    // Entry fill
    always_ff @(posedge VB) begin
        if (slot.done) begin
            tag        <= addr;
            cache_data <= slot.dout[DW-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_slot_port.sv ====
`default_nettype none

module ram_slot_port (
    input  logic                             VB,
    input  logic                             reset,
    input  logic                             cs,
    input  logic [cps_mem_pkg::SDRAM_AW-1:0] addr,
    input  logic                             rnw,
    input  logic [1:0]                       dsn,
    input  logic [15:0]                      din,
    output logic [15:0]                      data,
    output logic                             ok,
    sdram_slot_if.client                     slot
);

    logic                             valid;
    logic [cps_mem_pkg::SDRAM_AW-1:0] tag;
    logic [15:0]                      cache_data;
    logic                             hit;
    logic                             wr_done;
    logic                             need_req;

    assign hit      = valid && (tag == addr);
    assign need_req = rnw ? !hit : !wr_done;
    assign ok       = cs && (rnw ? hit : wr_done);
    assign data     = cache_data;

    // Writes always reach SDRAM, dsn is active low per byte
    assign slot.addr   = addr;
    assign slot.wr     = !rnw;
    assign slot.din    = din;
    assign slot.wrmask = dsn;

    always_ff @(posedge VB) begin
        if (reset) begin
            slot.req <= 1'b0;
            valid    <= 1'b0;
            wr_done  <= 1'b0;
        end else begin
            if (slot.done) begin
                slot.req <= 1'b0;
                if (rnw) begin
                    valid <= 1'b1;
                end else begin
                    valid   <= 1'b0;
                    wr_done <= 1'b1;
                end
            end else if (cs && need_req) begin
                slot.req <= 1'b1;
            end
            // Write ack lasts until the CPU releases cs
            if (!cs) begin
                wr_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (slot.done && rnw) begin
            tag        <= addr;
            cache_data <= slot.dout[15:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sdram_arbiter.sv ====
`default_nettype none

module sdram_arbiter (
    input  logic                             VB,
    input  logic                             reset,
    input  logic                             downloading,
    sdram_slot_if.arbiter                    main_rom,
    sdram_slot_if.arbiter                    main_ram,
    sdram_slot_if.arbiter                    gfx,
    sdram_slot_if.arbiter                    sound,
    output logic                             sdram_req,
    output logic [cps_mem_pkg::SDRAM_AW-1:0] sdram_addr,
    output cps_mem_pkg::sdram_bank_e         sdram_bank,
    output logic                             sdram_rnw,
    output logic [1:0]                       sdram_wrmask,
    output logic [15:0]                      data_write,
    input  logic                             sdram_ack,
    input  logic                             data_rdy,
    input  logic [cps_mem_pkg::SLOT_DW-1:0]  data_read
);
    import cps_mem_pkg::*;

    arb_state_e          state;
    slot_id_e            grant;
    slot_id_e            sel_id;
    logic                any_req;
    logic                start;
    logic                finish;
    logic [SDRAM_AW-1:0] sel_addr;
    logic                sel_wr;
    logic [15:0]         sel_din;
    logic [1:0]          sel_mask;
    sdram_bank_e         sel_bank;

    assign any_req = main_rom.req | main_ram.req | gfx.req | sound.req;
    assign start   = (state == ARB_IDLE) && !downloading && any_req;
    assign finish  = (state == ARB_WAIT_DATA) && data_rdy;

    // Fixed priority pick, sound is the fallback
    always_comb begin
        sel_id   = SLOT_SOUND;
        sel_addr = sound.addr;
        sel_wr   = sound.wr;
        sel_din  = sound.din;
        sel_mask = sound.wrmask;
        sel_bank = BANK_SOUND;
        if (main_rom.req) begin
            sel_id   = SLOT_MAIN_ROM;
            sel_addr = main_rom.addr;
            sel_wr   = main_rom.wr;
            sel_din  = main_rom.din;
            sel_mask = main_rom.wrmask;
            sel_bank = BANK_CPU;
        end else if (main_ram.req) begin
            sel_id   = SLOT_MAIN_RAM;
            sel_addr = main_ram.addr;
            sel_wr   = main_ram.wr;
            sel_din  = main_ram.din;
            sel_mask = main_ram.wrmask;
            sel_bank = BANK_SOUND;
        end else if (gfx.req) begin
            sel_id   = SLOT_GFX;
            sel_addr = gfx.addr;
            sel_wr   = gfx.wr;
            sel_din  = gfx.din;
            sel_mask = gfx.wrmask;
            sel_bank = BANK_GFX;
        end
    end

    always_ff @(posedge VB) begin
        if (reset) begin
            state     <= ARB_IDLE;
            grant     <= SLOT_MAIN_ROM;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (start) begin
                        state     <= ARB_WAIT_ACK;
                        grant     <= sel_id;
                        sdram_req <= 1'b1;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Request fields stay put for the whole transaction
    always_ff @(posedge VB) begin
        if (start) begin
            sdram_addr   <= sel_addr;
            sdram_bank   <= sel_bank;
            sdram_rnw    <= !sel_wr;
            sdram_wrmask <= sel_mask;
            data_write   <= sel_din;
        end
    end

    // Only the granted slot sees done
    assign main_rom.done = finish && (grant == SLOT_MAIN_ROM);
    assign main_ram.done = finish && (grant == SLOT_MAIN_RAM);
    assign gfx.done      = finish && (grant == SLOT_GFX);
    assign sound.done    = finish && (grant == SLOT_SOUND);

    assign main_rom.dout = data_read;
    assign main_ram.dout = data_read;
    assign gfx.dout      = data_read;
    assign sound.dout    = data_read;

endmodule

`default_nettype wire

// ==== rtl/cps_sdram_top.sv ====
`default_nettype none

module cps_sdram_top (
    input  logic        VB,
    input  logic        reset,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_bank,
    output logic        prog_we,
    input  logic        main_rom_cs,
    input  logic [20:0] main_rom_addr,
    output logic [15:0] main_rom_data,
    output logic        main_rom_ok,
    input  logic        main_ram_cs,
    input  logic        main_vram_cs,
    input  logic [16:0] ram_addr,
    input  logic        main_rnw,
    input  logic [1:0]  main_dsn,
    input  logic [15:0] main_dout,
    output logic [15:0] main_ram_data,
    output logic        main_ram_ok,
    input  logic        gfx_cs,
    input  logic [19:0] gfx_addr,
    output logic [31:0] gfx_data,
    output logic        gfx_ok,
    input  logic        snd_cs,
    input  logic [15:0] snd_addr,
    output logic [7:0]  snd_data,
    output logic        snd_ok,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    output logic [1:0]  sdram_bank,
    output logic        sdram_rnw,
    output logic [1:0]  sdram_wrmask,
    output logic [15:0] data_write,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read
);
    import cps_mem_pkg::*;

    logic [SDRAM_AW-1:0] rom_word;
    logic [SDRAM_AW-1:0] ram_word;
    logic [SDRAM_AW-1:0] gfx_word;
    logic [SDRAM_AW-1:0] snd_word;
    logic                ram_any_cs;
    logic [15:0]         snd_word_data;

    sdram_slot_if rom_if ();
    sdram_slot_if ram_if ();
    sdram_slot_if gfx_if ();
    sdram_slot_if snd_if ();

    // Slot address to SDRAM word address
    assign rom_word   = {1'b0, main_rom_addr};
    assign ram_word   = (main_vram_cs ? VRAM_OFFSET : RAM_OFFSET) + {5'd0, ram_addr};
    assign gfx_word   = GFX_OFFSET + {1'b0, gfx_addr, 1'b0};
    assign snd_word   = SOUND_OFFSET + {7'd0, snd_addr[15:1]};
    assign ram_any_cs = main_ram_cs | main_vram_cs;

    // Sound CPU reads bytes, even address is the low byte
    assign snd_data = snd_addr[0] ? snd_word_data[15:8] : snd_word_data[7:0];

    rom_loader u_loader (
        .VB          (VB),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_bank   (prog_bank),
        .prog_we     (prog_we)
    );

    rom_slot_cache #(.DW(16)) u_main_rom (
        .VB    (VB),
        .reset (reset),
        .cs    (main_rom_cs),
        .addr  (rom_word),
        .data  (main_rom_data),
        .ok    (main_rom_ok),
        .slot  (rom_if.client)
    );

    ram_slot_port u_main_ram (
        .VB    (VB),
        .reset (reset),
        .cs    (ram_any_cs),
        .addr  (ram_word),
        .rnw   (main_rnw),
        .dsn   (main_dsn),
        .din   (main_dout),
        .data  (main_ram_data),
        .ok    (main_ram_ok),
        .slot  (ram_if.client)
    );

    rom_slot_cache #(.DW(32)) u_gfx (
        .VB    (VB),
        .reset (reset),
        .cs    (gfx_cs),
        .addr  (gfx_word),
        .data  (gfx_data),
        .ok    (gfx_ok),
        .slot  (gfx_if.client)
    );

    rom_slot_cache #(.DW(16)) u_sound (
        .VB    (VB),
        .reset (reset),
        .cs    (snd_cs),
        .addr  (snd_word),
        .data  (snd_word_data),
        .ok    (snd_ok),
        .slot  (snd_if.client)
    );

    sdram_arbiter u_arbiter (
        .VB           (VB),
        .reset        (reset),
        .downloading  (downloading),
        .main_rom     (rom_if.arbiter),
        .main_ram     (ram_if.arbiter),
        .gfx          (gfx_if.arbiter),
        .sound        (snd_if.arbiter),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .sdram_bank   (sdram_bank),
        .sdram_rnw    (sdram_rnw),
        .sdram_wrmask (sdram_wrmask),
        .data_write   (data_write),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .data_read    (data_read)
    );

endmodule

`default_nettype wire

// ==== bench/sdram_arbiter_props.sv ====
`default_nettype none

module sdram_arbiter_props (
    input logic        VB,
    input logic        reset,
    input logic        downloading,
    input logic        sdram_req,
    input logic        sdram_ack,
    input logic [21:0] sdram_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // Request holds with a stable address until acknowledged
    req_held: assert property (@(posedge VB) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req dropped or address moved before sdram_ack");

    no_req_in_download: assert property (@(posedge VB) disable iff (reset)
        $rose(sdram_req) |-> !$past(downloading))
        else $error("sdram_req started while downloading");

    idle_after_reset: assert property (@(posedge VB)
        $past(reset) |-> !sdram_req)
        else $error("sdram_req high right after reset");

endmodule

bind sdram_arbiter sdram_arbiter_props u_props (.*);

`default_nettype wire

// ==== bench/cps_sdram_tb.sv ====
`default_nettype none

module cps_sdram_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        VB;
    logic        reset;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_bank;
    logic        prog_we;
    logic        main_rom_cs;
    logic [20:0] main_rom_addr;
    logic [15:0] main_rom_data;
    logic        main_rom_ok;
    logic        main_ram_cs;
    logic        main_vram_cs;
    logic [16:0] ram_addr;
    logic        main_rnw;
    logic [1:0]  main_dsn;
    logic [15:0] main_dout;
    logic [15:0] main_ram_data;
    logic        main_ram_ok;
    logic        gfx_cs;
    logic [19:0] gfx_addr;
    logic [31:0] gfx_data;
    logic        gfx_ok;
    logic        snd_cs;
    logic [15:0] snd_addr;
    logic [7:0]  snd_data;
    logic        snd_ok;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic [1:0]  sdram_bank;
    logic        sdram_rnw;
    logic [1:0]  sdram_wrmask;
    logic [15:0] data_write;
    logic        sdram_ack;
    logic        data_rdy;
    logic [31:0] data_read;

    // SDRAM contents keyed by {bank, word address}
    logic [15:0] mem [logic [23:0]];
    logic [1:0]  bank_log[$];
    int          req_count;
    int          mstate;
    int          wait_cnt;
    logic        prog_txn;
    logic        prog_acked;
    logic [31:0] lfsr;

    string       ops[$];
    logic [31:0] p_addr[$];
    logic [31:0] p_data[$];
    logic [31:0] p_exp[$];
    int          value_errs;
    int          other_errs;
    int          cycles;
    int          limit;

    cps_sdram_top UUT (.*);

    initial begin
        VB = 1'b0;
        forever #5 VB = ~VB;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // Delay of 1 to 4 cycles from two LFSR bits
    function automatic int rand_delay();
        int v;
        v = 0;
        for (int i = 0; i < 2; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v + 1;
    endfunction

    function automatic logic [15:0] read_word(input logic [1:0] bank, input logic [21:0] a);
        if (mem.exists({bank, a})) begin
            return mem[{bank, a}];
        end
        return a[15:0] ^ 16'hA5C3;
    endfunction

    // A set mask bit keeps that byte lane
    task automatic write_word(input logic [1:0] bank, input logic [21:0] a,
                              input logic [15:0] d, input logic [1:0] mask);
        logic [15:0] w;
        w = read_word(bank, a);
        if (!mask[0]) w[7:0] = d[7:0];
        if (!mask[1]) w[15:8] = d[15:8];
        mem[{bank, a}] = w;
    endtask

    // SDRAM controller model with late ack and data
    always @(negedge VB) begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        if (reset) begin
            mstate     = 0;
            prog_acked = 1'b0;
        end else begin
            case (mstate)
                0: begin
                    check_true(!(prog_acked && prog_we),
                               "prog_we stayed high after sdram_ack");
                    prog_acked = 1'b0;
                    if (prog_we || sdram_req) begin
                        wait_cnt = rand_delay();
                        prog_txn = prog_we;
                        mstate   = 1;
                        if (!prog_we) begin
                            bank_log.push_back(sdram_bank);
                            req_count++;
                        end
                    end
                end
                1: begin
                    wait_cnt--;
                    if (wait_cnt == 0) begin
                        sdram_ack = 1'b1;
                        if (prog_txn) begin
                            check_true(prog_we, "prog_we dropped before sdram_ack");
                            write_word(prog_bank, prog_addr, {prog_data, prog_data},
                                       prog_mask);
                            prog_acked = 1'b1;
                            mstate     = 0;
                        end else begin
                            if (!sdram_rnw) begin
                                write_word(sdram_bank, sdram_addr, data_write, sdram_wrmask);
                            end
                            wait_cnt = rand_delay();
                            mstate   = 2;
                        end
                    end
                end
                2: begin
                    wait_cnt--;
                    if (wait_cnt == 0) begin
                        data_rdy  = 1'b1;
                        data_read = {read_word(sdram_bank, sdram_addr + 22'd1),
                                     read_word(sdram_bank, sdram_addr)};
                        mstate    = 0;
                    end
                end
                default: mstate = 0;
            endcase
        end
    end

    always @(posedge VB) begin
        cycles++;
        if (cycles > limit) begin
            $display("Run stopped after reaching the limit of %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp == got) else begin
            value_errs++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            other_errs++;
            $display("%0t: %s", $time, msg);
        end
    endtask

    task automatic release_inputs();
        ioctl_wr     = 1'b0;
        main_rom_cs  = 1'b0;
        main_ram_cs  = 1'b0;
        main_vram_cs = 1'b0;
        gfx_cs       = 1'b0;
        snd_cs       = 1'b0;
        main_rnw     = 1'b1;
        main_dsn     = 2'b11;
    endtask

    task automatic pulse_reset();
        reset = 1'b1;
        repeat (3) @(negedge VB);
        reset = 1'b0;
    endtask

    task automatic load_patterns();
        int    fd;
        string line;
        string op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("bench/cps_sdram_patterns.txt", "r");
        check_true(fd != 0, "pattern file could not be opened");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
                    ops.push_back(op);
                    p_addr.push_back(a);
                    p_data.push_back(d);
                    p_exp.push_back(e);
                end
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    task automatic run_pattern(input string op, input logic [31:0] a,
                               input logic [31:0] d, input logic [31:0] e);
        int start_cnt;
        int first;
        logic [11:0] order;
        start_cnt = req_count;
        first     = bank_log.size();
        case (op)
            "D": begin
                downloading   = 1'b1;
                ioctl_addr    = a[24:0];
                ioctl_data    = d[7:0];
                ioctl_wr      = 1'b1;
                // ROM read left pending until the download ends
                main_rom_cs   = 1'b1;
                main_rom_addr = a[20:0];
                @(negedge VB);
                ioctl_wr = 1'b0;
                while (!prog_we) @(negedge VB);
                compare_value("prog_fields", e, {6'd0, prog_bank, prog_mask, prog_addr});
                compare_value("prog_data", d, {24'd0, prog_data});
                while (prog_we) @(negedge VB);
                check_true(!sdram_req, "SDRAM request started during download");
                downloading = 1'b0;
                while (!main_rom_ok) @(negedge VB);
            end
            "R", "H": begin
                main_rom_cs   = 1'b1;
                main_rom_addr = a[20:0];
                #1;
                if (op == "H") begin
                    check_true(main_rom_ok, "ROM reread did not hit in the cache");
                end
                while (!main_rom_ok) @(negedge VB);
                compare_value("main_rom_data", e, {16'd0, main_rom_data});
                if (op == "H") begin
                    // Long enough for a miss to reach the SDRAM pins
                    repeat (3) @(negedge VB);
                    check_true(req_count == start_cnt && !sdram_req,
                               "ROM reread issued an SDRAM request");
                end else begin
                    check_true(bank_log.size() > first && bank_log[first] == 2'd1,
                               "ROM read did not use the CPU bank");
                end
            end
            "W", "M", "V": begin
                main_ram_cs  = (op != "V");
                main_vram_cs = (op == "V");
                ram_addr     = a[16:0];
                main_rnw     = (op != "W");
                main_dsn     = (op == "W") ? e[1:0] : 2'b11;
                main_dout    = d[15:0];
                @(negedge VB);
                while (!main_ram_ok) @(negedge VB);
                if (op != "W") begin
                    compare_value("main_ram_data", e, {16'd0, main_ram_data});
                end
            end
            "G": begin
                gfx_cs   = 1'b1;
                gfx_addr = a[19:0];
                while (!gfx_ok) @(negedge VB);
                compare_value("gfx_data", e, gfx_data);
                check_true(bank_log.size() > first && bank_log[first] == 2'd2,
                           "graphics read did not use the graphics bank");
            end
            "S": begin
                snd_cs   = 1'b1;
                snd_addr = a[15:0];
                #1;
                while (!snd_ok) @(negedge VB);
                compare_value("snd_data", e, {24'd0, snd_data});
            end
            "C": begin
                main_rom_cs   = 1'b1;
                main_rom_addr = a[20:0];
                gfx_cs        = 1'b1;
                gfx_addr      = a[19:0];
                snd_cs        = 1'b1;
                snd_addr      = a[15:0];
                while (!(main_rom_ok && gfx_ok && snd_ok)) @(negedge VB);
                check_true(bank_log.size() == first + 3, "concurrent reads gave wrong request count");
                if (bank_log.size() == first + 3) begin
                    order = {2'd0, bank_log[first], 2'd0, bank_log[first + 1],
                             2'd0, bank_log[first + 2]};
                    compare_value("sdram_bank_order", e, {20'd0, order});
                end
            end
            default: check_true(1'b0, "unknown operation in pattern file");
        endcase
        @(negedge VB);
        release_inputs();
        downloading = 1'b0;
        @(negedge VB);
    endtask

    initial begin
        reset         = 1'b1;
        downloading   = 1'b0;
        ioctl_addr    = '0;
        ioctl_data    = '0;
        main_rom_addr = '0;
        ram_addr      = '0;
        main_dout     = '0;
        gfx_addr      = '0;
        snd_addr      = '0;
        sdram_ack     = 1'b0;
        data_rdy      = 1'b0;
        data_read     = '0;
        lfsr          = 32'h88f7_43a6;
        limit         = 100000;
        release_inputs();
        load_patterns();
        limit = 40 * ops.size() + 200;
        repeat (3) @(negedge VB);
        reset = 1'b0;
        for (int i = 0; i < ops.size(); i++) begin
            // Host resets the board once the download is over
            if (i > 0 && ops[i - 1] == "D" && ops[i] != "D") begin
                pulse_reset();
            end
            run_pattern(ops[i], p_addr[i], p_data[i], p_exp[i]);
        end
        check_true(ops.size() > 0, "no patterns were run");
        $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cps_sdram_patterns.txt ====
# op addr data expected, all hex; D exp = {bank, mask, word}, W exp = dsn
# C drives ROM, graphics and sound with one addr, exp = bank order one nibble each
D 0000010 5a 1800008
D 0200005 3c 0400002
D 0240007 e1 2400003
R 001234 0 b7f7
H 001234 0 b7f7
W 00040 beef 2
M 00040 0 a5ef
V 00040 0 a583
G 00100 0 a7c2a7c3
S 0101 0 a5
S 0100 0 43
C 00300 0 120

// ==== sources.f ====
rtl/cps_mem_pkg.sv
rtl/sdram_slot_if.sv
rtl/rom_loader.sv
rtl/rom_slot_cache.sv
rtl/ram_slot_port.sv
rtl/sdram_arbiter.sv
rtl/cps_sdram_top.sv
bench/sdram_arbiter_props.sv
bench/cps_sdram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cps_sdram_tb -f sources.f -o sim_cps
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cps > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' sim.log; then
    exit 0
fi
exit 1
